// ==== axil_pkg.sv ====
// Shared widths, SRAM depth, AXI-lite response codes and word types for the memory subsystem
`default_nettype none

package axil_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int ADDR_W     = 32;           // Byte address
  localparam int DATA_W     = 64;
  localparam int STRB_W     = DATA_W / 8;   // One strobe bit per byte lane

  // --------------------------------------------------------------------------
  // On-chip SRAM geometry
  // --------------------------------------------------------------------------
  localparam int MEM_WORDS  = 256;
  localparam int WORD_IDX_W = 8;            // log2 of MEM_WORDS

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [1:0]        resp_t;

  // AXI response encodings
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;    // Address outside the SRAM

endpackage

`default_nettype wire

// ==== axil_req_stage.sv ====
// Request register stage that latches one requester access and holds it for the AXI-lite master
`timescale 1ns/1ps
`default_nettype none

module axil_req_stage (
  input  wire              i_aclk,
  input  wire              i_rst_n,
  // Requester port
  input  wire              i_rw_valid,
  input  wire              i_rw_ren,
  input  wire              i_rw_wen,
  input  wire axil_pkg::addr_t i_rw_addr,
  input  wire axil_pkg::data_t i_rw_w_data,
  input  wire axil_pkg::strb_t i_rw_strb,
  // Toward the master
  output logic             o_req_start,
  output logic             o_req_is_write,
  output axil_pkg::addr_t  o_req_addr,
  output axil_pkg::data_t  o_req_wdata,
  output axil_pkg::strb_t  o_req_strb,
  // Back from the master
  input  wire              i_addr_ok,
  input  wire              i_data_ok,
  input  wire axil_pkg::data_t i_rdata,
  input  wire axil_pkg::resp_t i_resp,
  // Requester status
  output logic             o_rw_addr_ok,
  output logic             o_rw_data_ok,
  output axil_pkg::data_t  o_rw_rdata,
  output axil_pkg::resp_t  o_rw_resp
);

  import axil_pkg::*;

  logic  busy;        // Access in flight
  logic  start_q;
  logic  take;
  logic  is_write_q;
  addr_t addr_q;
  data_t wdata_q;
  strb_t strb_q;

  // New access only when idle and one direction is asked for
  assign take = i_rw_valid & (i_rw_ren | i_rw_wen) & ~busy;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      busy    <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= take;              // One-cycle start after latching
      if (take) begin
        busy <= 1'b1;
      end else if (i_data_ok) begin
        busy <= 1'b0;
      end
    end
  end

  // Request fields stay frozen until completion
  always_ff @(posedge i_aclk) begin
    if (take) begin
      is_write_q <= i_rw_wen;
      addr_q     <= i_rw_addr;
      wdata_q    <= i_rw_w_data;
      strb_q     <= i_rw_strb;
    end
  end

  assign o_req_start    = start_q;
  assign o_req_is_write = is_write_q;
  assign o_req_addr     = addr_q;
  assign o_req_wdata    = wdata_q;
  assign o_req_strb     = strb_q;

  assign o_rw_addr_ok   = i_addr_ok;
  assign o_rw_data_ok   = i_data_ok;
  assign o_rw_rdata     = i_rdata;
  assign o_rw_resp      = i_resp;

  // Requester must never ask for read and write together
  a_one_dir: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_rw_valid |-> !(i_rw_ren && i_rw_wen));

  // Master completes only what this stage handed over
  a_done_busy: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_data_ok |-> busy);

endmodule

`default_nettype wire

// ==== axil_master.sv ====
// AXI-lite master with separate read and write FSMs that turns one latched request into bus traffic
`timescale 1ns/1ps
`default_nettype none

module axil_master (
  input  wire              i_aclk,
  input  wire              i_rst_n,
  // Latched request
  input  wire              i_req_start,
  input  wire              i_req_is_write,
  input  wire axil_pkg::addr_t i_req_addr,
  input  wire axil_pkg::data_t i_req_wdata,
  input  wire axil_pkg::strb_t i_req_strb,
  output logic             o_addr_ok,
  output logic             o_data_ok,
  output axil_pkg::data_t  o_rdata,
  output axil_pkg::resp_t  o_resp,
  // Write address channel
  output logic             o_awvalid,
  input  wire              i_awready,
  output axil_pkg::addr_t  o_awaddr,
  // Write data channel
  output logic             o_wvalid,
  input  wire              i_wready,
  output axil_pkg::data_t  o_wdata,
  output axil_pkg::strb_t  o_wstrb,
  // Write response channel
  input  wire              i_bvalid,
  output logic             o_bready,
  input  wire axil_pkg::resp_t i_bresp,
  // Read address channel
  output logic             o_arvalid,
  input  wire              i_arready,
  output axil_pkg::addr_t  o_araddr,
  // Read data channel
  input  wire              i_rvalid,
  output logic             o_rready,
  input  wire axil_pkg::data_t i_rdata,
  input  wire axil_pkg::resp_t i_rresp
);

  import axil_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_READ
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_WRITE,
    WR_RESP
  } wr_state_e;

  rd_state_e rd_state;
  wr_state_e wr_state;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  // Handshake strobes
  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid  & i_wready;
  assign b_fire  = o_bready  & i_bvalid;
  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = o_rready  & i_rvalid;

  // --------------------------------------------------------------------------
  // Read FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (i_req_start && !i_req_is_write) rd_state <= RD_ADDR;
        RD_ADDR: if (ar_fire) rd_state <= RD_READ;
        RD_READ: if (r_fire) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Write FSM steps through address, data and response in order
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE:  if (i_req_start && i_req_is_write) wr_state <= WR_ADDR;
        WR_ADDR:  if (aw_fire) wr_state <= WR_WRITE;
        WR_WRITE: if (w_fire) wr_state <= WR_RESP;
        WR_RESP:  if (b_fire) wr_state <= WR_IDLE;
        default:  wr_state <= WR_IDLE;
      endcase
    end
  end

  // Channel controls straight from state
  assign o_awvalid = (wr_state == WR_ADDR);
  assign o_wvalid  = (wr_state == WR_WRITE);
  assign o_bready  = (wr_state == WR_RESP);
  assign o_arvalid = (rd_state == RD_ADDR);
  assign o_rready  = (rd_state == RD_READ);

  assign o_awaddr  = i_req_addr;
  assign o_wdata   = i_req_wdata;
  assign o_wstrb   = i_req_strb;
  assign o_araddr  = i_req_addr;

  // Write acceptance counts at the data beat
  assign o_addr_ok = ar_fire | w_fire;
  assign o_data_ok = r_fire  | b_fire;
  assign o_rdata   = i_rdata;
  assign o_resp    = (wr_state == WR_RESP) ? i_bresp : i_rresp;

  // Valid and payload hold until the ready
  a_aw_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr));
  a_w_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_wvalid && !i_wready |=> o_wvalid && $stable(o_wdata) && $stable(o_wstrb));
  a_ar_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

  // Only one access at a time
  a_one_fsm: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    !(rd_state != RD_IDLE && wr_state != WR_IDLE));

endmodule

`default_nettype wire

// ==== axil_sram_slave.sv ====
// AXI-lite slave over a byte-strobed word SRAM, answers SLVERR for addresses past its end
`timescale 1ns/1ps
`default_nettype none

module axil_sram_slave (
  input  wire              i_aclk,
  input  wire              i_rst_n,
  // Write address channel
  input  wire              i_awvalid,
  output logic             o_awready,
  input  wire axil_pkg::addr_t i_awaddr,
  // Write data channel
  input  wire              i_wvalid,
  output logic             o_wready,
  input  wire axil_pkg::data_t i_wdata,
  input  wire axil_pkg::strb_t i_wstrb,
  // Write response channel
  output logic             o_bvalid,
  input  wire              i_bready,
  output axil_pkg::resp_t  o_bresp,
  // Read address channel
  input  wire              i_arvalid,
  output logic             o_arready,
  input  wire axil_pkg::addr_t i_araddr,
  // Read data channel
  output logic             o_rvalid,
  input  wire              i_rready,
  output axil_pkg::data_t  o_rdata,
  output axil_pkg::resp_t  o_rresp
);

  import axil_pkg::*;

  data_t mem [MEM_WORDS];

  logic                  awready_q;
  logic                  wready_q;
  logic                  arready_q;
  logic                  bvalid_q;
  logic                  rvalid_q;
  logic                  aw_pend;     // Address taken, data beat not yet
  logic [WORD_IDX_W-1:0] aw_idx_q;
  logic                  aw_ok_q;
  resp_t                 bresp_q;
  data_t                 rdata_q;
  resp_t                 rresp_q;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  function automatic logic in_range(addr_t a);
    return a < addr_t'(MEM_WORDS * STRB_W);
  endfunction

  function automatic logic [WORD_IDX_W-1:0] word_idx(addr_t a);
    return a[$clog2(STRB_W) +: WORD_IDX_W];   // Bits 10:3
  endfunction

  assign aw_fire = i_awvalid & awready_q;
  assign w_fire  = i_wvalid  & wready_q;
  assign b_fire  = bvalid_q  & i_bready;
  assign ar_fire = i_arvalid & arready_q;
  assign r_fire  = rvalid_q  & i_rready;

  // --------------------------------------------------------------------------
  // Handshake control
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      arready_q <= 1'b0;
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
      aw_pend   <= 1'b0;
    end else begin
      // Each ready is a single-cycle pulse one cycle after valid
      awready_q <= i_awvalid & ~awready_q & ~aw_pend & ~bvalid_q;
      wready_q  <= i_wvalid & ~wready_q & aw_pend;
      arready_q <= i_arvalid & ~arready_q & ~rvalid_q;

      if (aw_fire) begin
        aw_pend <= 1'b1;
      end else if (w_fire) begin
        aw_pend <= 1'b0;
      end

      if (w_fire) begin
        bvalid_q <= 1'b1;
      end else if (b_fire) begin
        bvalid_q <= 1'b0;             // Held until master takes it
      end

      if (ar_fire) begin
        rvalid_q <= 1'b1;
      end else if (r_fire) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Latched address and response payload
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      aw_idx_q <= word_idx(i_awaddr);
      aw_ok_q  <= in_range(i_awaddr);
    end
    if (w_fire) begin
      bresp_q <= aw_ok_q ? RESP_OKAY : RESP_SLVERR;
    end
    if (ar_fire) begin
      rdata_q <= in_range(i_araddr) ? mem[word_idx(i_araddr)] : '0;
      rresp_q <= in_range(i_araddr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // --------------------------------------------------------------------------
  // SRAM array
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (w_fire && aw_ok_q) begin
      // Byte lane merge under wstrb
      for (int b = 0; b < STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[aw_idx_q][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  assign o_awready = awready_q;
  assign o_wready  = wready_q;
  assign o_arready = arready_q;
  assign o_bvalid  = bvalid_q;
  assign o_bresp   = bresp_q;
  assign o_rvalid  = rvalid_q;
  assign o_rdata   = rdata_q;
  assign o_rresp   = rresp_q;

  // A write response always follows a data beat
  a_b_after_w: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    $rose(o_bvalid) |-> $past(w_fire));

  // Read response stays put while the master stalls
  a_r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

endmodule

`default_nettype wire

// ==== axil_mem_top.sv ====
// Memory access subsystem top that chains request stage, AXI-lite master and SRAM slave
`timescale 1ns/1ps
`default_nettype none

module axil_mem_top (
  input  wire              i_aclk,
  input  wire              i_rst_n,
  input  wire              i_rw_valid,
  input  wire              i_rw_ren,
  input  wire              i_rw_wen,
  input  wire axil_pkg::addr_t i_rw_addr,
  input  wire axil_pkg::data_t i_rw_w_data,
  input  wire axil_pkg::strb_t i_rw_strb,
  output logic             o_rw_addr_ok,
  output logic             o_rw_data_ok,
  output axil_pkg::data_t  o_rw_rdata,
  output axil_pkg::resp_t  o_rw_resp
);

  import axil_pkg::*;

  // Request stage to master
  logic  req_start;
  logic  req_is_write;
  addr_t req_addr;
  data_t req_wdata;
  strb_t req_strb;
  logic  addr_ok;
  logic  data_ok;
  data_t mst_rdata;
  resp_t mst_resp;

  // --------------------------------------------------------------------------
  // AXI-lite bus between master and slave
  // --------------------------------------------------------------------------
  logic  awvalid, awready;
  addr_t awaddr;
  logic  wvalid, wready;
  data_t wdata;
  strb_t wstrb;
  logic  bvalid, bready;
  resp_t bresp;
  logic  arvalid, arready;
  addr_t araddr;
  logic  rvalid, rready;
  data_t rdata;
  resp_t rresp;

  axil_req_stage u_req_stage (
    .i_aclk         (i_aclk),
    .i_rst_n        (i_rst_n),
    .i_rw_valid     (i_rw_valid),
    .i_rw_ren       (i_rw_ren),
    .i_rw_wen       (i_rw_wen),
    .i_rw_addr      (i_rw_addr),
    .i_rw_w_data    (i_rw_w_data),
    .i_rw_strb      (i_rw_strb),
    .o_req_start    (req_start),
    .o_req_is_write (req_is_write),
    .o_req_addr     (req_addr),
    .o_req_wdata    (req_wdata),
    .o_req_strb     (req_strb),
    .i_addr_ok      (addr_ok),
    .i_data_ok      (data_ok),
    .i_rdata        (mst_rdata),
    .i_resp         (mst_resp),
    .o_rw_addr_ok   (o_rw_addr_ok),
    .o_rw_data_ok   (o_rw_data_ok),
    .o_rw_rdata     (o_rw_rdata),
    .o_rw_resp      (o_rw_resp)
  );

  axil_master u_master (
    .i_aclk         (i_aclk),
    .i_rst_n        (i_rst_n),
    .i_req_start    (req_start),
    .i_req_is_write (req_is_write),
    .i_req_addr     (req_addr),
    .i_req_wdata    (req_wdata),
    .i_req_strb     (req_strb),
    .o_addr_ok      (addr_ok),
    .o_data_ok      (data_ok),
    .o_rdata        (mst_rdata),
    .o_resp         (mst_resp),
    .o_awvalid      (awvalid),
    .i_awready      (awready),
    .o_awaddr       (awaddr),
    .o_wvalid       (wvalid),
    .i_wready       (wready),
    .o_wdata        (wdata),
    .o_wstrb        (wstrb),
    .i_bvalid       (bvalid),
    .o_bready       (bready),
    .i_bresp        (bresp),
    .o_arvalid      (arvalid),
    .i_arready      (arready),
    .o_araddr       (araddr),
    .i_rvalid       (rvalid),
    .o_rready       (rready),
    .i_rdata        (rdata),
    .i_rresp        (rresp)
  );

  axil_sram_slave u_sram (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_awaddr  (awaddr),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_bresp   (bresp),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_araddr  (araddr),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_rdata   (rdata),
    .o_rresp   (rresp)
  );

endmodule

`default_nettype wire

// ==== tb_axil_mem_top.sv ====
// Random-stimulus testbench for the memory top that checks every access against a memory model
`timescale 1ns/1ps
`default_nettype none

module tb_axil_mem_top;

  import axil_pkg::*;

  localparam int N_RAND         = 300;
  localparam int TIMEOUT_CYCLES = (N_RAND + 10) * 20 + 100;

  logic  i_aclk;
  logic  i_rst_n;
  logic  i_rw_valid;
  logic  i_rw_ren;
  logic  i_rw_wen;
  addr_t i_rw_addr;
  data_t i_rw_w_data;
  strb_t i_rw_strb;
  logic  o_rw_addr_ok;
  logic  o_rw_data_ok;
  data_t o_rw_rdata;
  resp_t o_rw_resp;

  data_t ref_mem [MEM_WORDS];   // Expected SRAM contents
  int    data_errs;
  int    resp_errs;
  int    pulse_errs;
  int    cycles;

  axil_mem_top DUT (
    .i_aclk       (i_aclk),
    .i_rst_n      (i_rst_n),
    .i_rw_valid   (i_rw_valid),
    .i_rw_ren     (i_rw_ren),
    .i_rw_wen     (i_rw_wen),
    .i_rw_addr    (i_rw_addr),
    .i_rw_w_data  (i_rw_w_data),
    .i_rw_strb    (i_rw_strb),
    .o_rw_addr_ok (o_rw_addr_ok),
    .o_rw_data_ok (o_rw_data_ok),
    .o_rw_rdata   (o_rw_rdata),
    .o_rw_resp    (o_rw_resp)
  );

  initial begin
    i_aclk = 1'b0;
    forever #5 i_aclk = ~i_aclk;
  end

  // Run limit
  always @(posedge i_aclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: requests still pending after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_data(input data_t got, input data_t exp, input string msg);
    if (got !== exp) begin
      data_errs++;
      $display("Error at %0t ns: %s data %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_resp(input resp_t got, input resp_t exp, input string msg);
    if (got !== exp) begin
      resp_errs++;
      $display("Error at %0t ns: %s resp %0d, expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic check_pulse(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      pulse_errs++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, msg, got, exp);
    end
  endtask

  // One access on the requester port returning what came back with data_ok
  task automatic do_access(input logic wr, input addr_t addr, input data_t wd,
                           input strb_t st, output data_t rd, output resp_t rs);
    int n_aok;
    bit done;
    n_aok = 0;
    done  = 0;
    @(posedge i_aclk);
    check_pulse(o_rw_addr_ok, 1'b0, "addr_ok between requests");
    check_pulse(o_rw_data_ok, 1'b0, "data_ok between requests");
    i_rw_valid  <= 1'b1;
    i_rw_ren    <= !wr;
    i_rw_wen    <= wr;
    i_rw_addr   <= addr;
    i_rw_w_data <= wd;
    i_rw_strb   <= st;
    while (!done) begin
      @(posedge i_aclk);
      if (o_rw_data_ok) begin
        // Address acceptance must come in an earlier cycle
        check_pulse(n_aok == 1 && !o_rw_addr_ok, 1'b1, "single addr_ok before data_ok");
        rd   = o_rw_rdata;
        rs   = o_rw_resp;
        done = 1;
      end else if (o_rw_addr_ok) begin
        n_aok++;
        i_rw_valid  <= 1'b0;
        i_rw_ren    <= 1'b0;
        i_rw_wen    <= 1'b0;
        i_rw_addr   <= $urandom;            // Stage must hold its own copy
        i_rw_w_data <= {$urandom, $urandom};
        i_rw_strb   <= strb_t'($urandom);
      end
    end
  endtask

  task automatic write_check(input addr_t addr, input data_t wd, input strb_t st);
    data_t rd;
    resp_t rs;
    logic  ok;
    ok = addr < MEM_WORDS * STRB_W;
    do_access(1'b1, addr, wd, st, rd, rs);
    check_resp(rs, ok ? RESP_OKAY : RESP_SLVERR, "write");
    if (ok) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (st[b]) ref_mem[addr[10:3]][8*b +: 8] = wd[8*b +: 8];
      end
    end
  endtask

  task automatic read_check(input addr_t addr);
    data_t rd;
    resp_t rs;
    logic  ok;
    ok = addr < MEM_WORDS * STRB_W;
    do_access(1'b0, addr, '0, '0, rd, rs);
    check_resp(rs, ok ? RESP_OKAY : RESP_SLVERR, "read");
    check_data(rd, ok ? ref_mem[addr[10:3]] : data_t'(0), "read");
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin
    int    idx;
    addr_t addr;
    void'($urandom(19566));
    data_errs   = 0;
    resp_errs   = 0;
    pulse_errs  = 0;
    cycles      = 0;
    i_rst_n     = 1'b0;
    i_rw_valid  = 1'b0;
    i_rw_ren    = 1'b0;
    i_rw_wen    = 1'b0;
    i_rw_addr   = '0;
    i_rw_w_data = '0;
    i_rw_strb   = '0;
    for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = '0;

    // Status pulses stay low in reset
    @(posedge i_aclk);
    repeat (7) begin
      @(posedge i_aclk);
      check_pulse(o_rw_addr_ok, 1'b0, "addr_ok in reset");
      check_pulse(o_rw_data_ok, 1'b0, "data_ok in reset");
    end
    i_rst_n <= 1'b1;

    // Full word then partial byte lanes
    write_check(32'h100, {$urandom, $urandom}, 8'hFF);
    read_check(32'h100);
    write_check(32'h100, {$urandom, $urandom}, 8'b0101_1010);
    read_check(32'h100);

    // Out of range aliases word 0 and word 255 in the low bits
    write_check(32'h000, 64'h0123_4567_89AB_CDEF, 8'hFF);
    write_check(32'h800, {$urandom, $urandom}, 8'hFF);
    read_check(32'h800);
    write_check(32'hFFFF_FFF8, {$urandom, $urandom}, 8'hFF);
    read_check(32'hFFFF_FFF8);
    read_check(32'h000);
    read_check(32'h7F8);

    for (int n = 0; n < N_RAND; n++) begin
      if ($urandom % 10 == 0) begin
        addr = $urandom | 32'h0000_0800;
      end else begin
        idx  = ($urandom % 4 == 0) ? $urandom % MEM_WORDS : $urandom % 16;   // Mostly a hot set
        addr = addr_t'(idx * 8 + $urandom % 8);
      end
      if ($urandom % 2) write_check(addr, {$urandom, $urandom}, strb_t'($urandom));
      else read_check(addr);
    end

    @(posedge i_aclk);
    $display("Errors: data %0d, resp %0d, protocol %0d", data_errs, resp_errs, pulse_errs);
    if (data_errs + resp_errs + pulse_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
axil_pkg.sv
axil_req_stage.sv
axil_master.sv
axil_sram_slave.sv
axil_mem_top.sv
tb_axil_mem_top.sv
